// File: lsu_top.f
hw/lsu_mem_pkg.sv
hw/lsu_op_pkg.sv
hw/lsu_ifs.sv
hw/lsu_req_align.sv
hw/lsu_txn_ctrl.sv
hw/lsu_wb_regs.sv
hw/lsu_rdata_align.sv
hw/lsu_obi_port.sv
hw/lsu_top.sv
test/lsu_mem_model.sv
test/tb_lsu_top.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = tb_lsu_top
FLIST = lsu_top.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: test/tb_lsu_top.sv
// testbench for the lsu top level
// drives EX-stage accesses, mirrors memory in a shadow copy and checks bus and load data

`timescale 1ns/1ps

module tb_lsu_top import lsu_mem_pkg::*, lsu_op_pkg::*; ();

  localparam size_t SZ_BYTE = 2'd2;

  logic clk, rst_n;
  logic data_req_ex, data_we_ex, addr_useincr_ex, data_misaligned_ex;
  size_t data_type_ex;
  ext_t data_sign_ext_ex;
  word_t data_wdata_ex, data_rdata_ex_o, data_wdata_o, data_rdata_i;
  offset_t data_reg_offset_ex;
  addr_t operand_a_ex, operand_b_ex, data_addr_o;
  logic data_misaligned_o, lsu_ready_ex_o, lsu_ready_wb_o, busy_o;
  logic data_req_o, data_gnt_i, data_rvalid_i, data_we_o;
  be_t data_be_o;

  logic [7:0] shadow [0:1023];     // byte copy of what memory should hold
  bit    chk_q [$];                // response check flag per granted access
  word_t val_q [$];
  addr_t exp_addr;
  be_t   exp_be;
  word_t exp_wdata;
  logic  exp_we, cur_chk;
  word_t cur_val;
  int    out_cnt, errors, checks, tests, err_mark, seed;

  lsu_top #(.DEPTH(2)) lsu_top_inst (
    .clk(clk), .rst_n(rst_n),
    .data_req_ex_i(data_req_ex), .data_we_ex_i(data_we_ex), .data_type_ex_i(data_type_ex),
    .data_sign_ext_ex_i(data_sign_ext_ex), .data_wdata_ex_i(data_wdata_ex),
    .data_reg_offset_ex_i(data_reg_offset_ex), .operand_a_ex_i(operand_a_ex),
    .operand_b_ex_i(operand_b_ex), .addr_useincr_ex_i(addr_useincr_ex),
    .data_misaligned_ex_i(data_misaligned_ex), .data_misaligned_o(data_misaligned_o),
    .data_rdata_ex_o(data_rdata_ex_o), .lsu_ready_ex_o(lsu_ready_ex_o),
    .lsu_ready_wb_o(lsu_ready_wb_o), .busy_o(busy_o),
    .data_req_o(data_req_o), .data_gnt_i(data_gnt_i), .data_rvalid_i(data_rvalid_i),
    .data_addr_o(data_addr_o), .data_we_o(data_we_o), .data_be_o(data_be_o),
    .data_wdata_o(data_wdata_o), .data_rdata_i(data_rdata_i)
  );

  lsu_mem_model u_mem (
    .clk(clk), .rst_n(rst_n), .req_i(data_req_o), .addr_i(data_addr_o), .we_i(data_we_o),
    .be_i(data_be_o), .wdata_i(data_wdata_o), .gnt_o(data_gnt_i),
    .rvalid_o(data_rvalid_i), .rdata_o(data_rdata_i)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check(input string name, input word_t got, input word_t exp);
    checks++;
    assert (got === exp) else begin
      $display("[FAIL] %0t %s got %h exp %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic abort(input string why);
    $display("%s at %0t", why, $time);
    $display("test failed");
    $finish;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("%-26s %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  function automatic int nbytes(input size_t s);
    return (s == SIZE_WORD) ? 4 : (s == SIZE_HALF) ? 2 : 1;
  endfunction

  function automatic bit split_needed(input size_t s, input int off);
    return (s == SIZE_WORD && off != 0) || (s == SIZE_HALF && off == 3);
  endfunction

  ////////////////////////////////
  // EX-stage drive
  ////////////////////////////////

  // one bus phase from a rising edge up to the edge where EX takes it
  task automatic drive_phase(input bit we, input size_t size, input ext_t ext, input addr_t addr,
                             input word_t wdata, input offset_t reg_off, input bit incr,
                             input bit phase2, input bit chk, input word_t val);
    int off;
    int k;
    int t;
    #2;
    off = int'(addr[1:0]);
    exp_be = '0;
    exp_wdata = '0;
    for (int i = 0; i < 4; i++) begin
      k = i + (phase2 ? 4 : 0) - off;     // byte index within the access
      if (k >= 0 && k < nbytes(size)) begin
        exp_be[i] = 1'b1;
        exp_wdata[8*i +: 8] = wdata[8*((k + int'(reg_off)) % 4) +: 8];
      end
    end
    exp_addr = phase2 ? {addr[31:2], 2'b00} : addr;
    exp_we  = we;
    cur_chk = chk;
    cur_val = val;
    data_req_ex = 1'b1;
    data_we_ex = we;
    data_type_ex = size;
    data_sign_ext_ex = ext;
    data_wdata_ex = wdata;
    data_reg_offset_ex = reg_off;
    addr_useincr_ex = incr;
    operand_a_ex = incr ? addr - 32'd6 : addr;
    operand_b_ex = 32'd6;                 // only added with incr set
    data_misaligned_ex = phase2;
    #1;
    check("data_misaligned_o", word_t'(data_misaligned_o),
          word_t'(!phase2 && split_needed(size, off)));
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (!lsu_ready_ex_o && t < 50);
    if (!lsu_ready_ex_o) abort("EX request never accepted");
  endtask

  // drops the request and waits for all responses
  task automatic wait_idle();
    int t;
    #2;
    data_req_ex = 1'b0;
    data_misaligned_ex = 1'b0;
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (out_cnt != 0 && t < 50);
    if (out_cnt != 0) abort("bus responses still missing");
  endtask

  task automatic do_load(input addr_t addr, input size_t size, input ext_t ext, input bit incr);
    word_t v;
    bit    fb;
    int    n;
    n = nbytes(size);
    v = '0;
    for (int k = 0; k < n; k++) v[8*k +: 8] = shadow[addr[9:0] + k];
    fb = (ext == EXT_ONES) ? 1'b1 : (ext == EXT_SIGN) ? v[8*n-1] : 1'b0;
    for (int k = n; k < 4; k++) v[8*k +: 8] = {8{fb}};
    if (split_needed(size, int'(addr[1:0]))) begin
      drive_phase(1'b0, size, ext, addr, '0, 2'd0, incr, 1'b0, 1'b0, '0);
      drive_phase(1'b0, size, ext, addr + 32'd4, '0, 2'd0, incr, 1'b1, 1'b1, v);
    end else begin
      drive_phase(1'b0, size, ext, addr, '0, 2'd0, incr, 1'b0, 1'b1, v);
    end
    wait_idle();
  endtask

  task automatic do_store(input addr_t addr, input size_t size, input word_t wdata,
                          input offset_t reg_off, input bit incr);
    for (int k = 0; k < nbytes(size); k++) begin
      shadow[addr[9:0] + k] = wdata[8*((k + int'(reg_off)) % 4) +: 8];
    end
    drive_phase(1'b1, size, EXT_ZERO, addr, wdata, reg_off, incr, 1'b0, 1'b0, '0);
    if (split_needed(size, int'(addr[1:0]))) begin
      drive_phase(1'b1, size, EXT_ZERO, addr + 32'd4, wdata, reg_off, incr, 1'b1, 1'b0, '0);
    end
    wait_idle();
  endtask

  ////////////////////////////////
  // bus monitor
  ////////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      if (data_req_o && data_gnt_i) begin
        check("data_addr_o", data_addr_o, exp_addr);
        check("data_be_o", word_t'(data_be_o), word_t'(exp_be));
        check("data_we_o", word_t'(data_we_o), word_t'(exp_we));
        if (exp_we) begin
          check("data_wdata_o", data_wdata_o & {{8{exp_be[3]}}, {8{exp_be[2]}},
                {8{exp_be[1]}}, {8{exp_be[0]}}}, exp_wdata);
        end
        chk_q.push_back(cur_chk);
        val_q.push_back(cur_val);
      end
      if (data_rvalid_i) begin
        if (chk_q.size() == 0) begin
          $display("response arrived with no granted request at %0t", $time);
          errors++;
        end else begin
          if (chk_q.pop_front()) check("data_rdata_ex_o", data_rdata_ex_o, val_q[0]);
          void'(val_q.pop_front());
        end
      end
      out_cnt <= out_cnt + int'(data_req_o && data_gnt_i) - int'(data_rvalid_i);
    end
  end

  a_depth: assert property (@(posedge clk) disable iff (!rst_n)
    out_cnt <= int'(lsu_top_inst.DEPTH)) else begin
    $display("more accesses in flight than DEPTH at %0t", $time);
    errors++;
  end

  a_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (out_cnt != 0) |-> busy_o) else begin
    $display("busy_o low with accesses in flight at %0t", $time);
    errors++;
  end

  // request and payload held until granted
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (data_req_o && !data_gnt_i) |=> (data_req_o &&
      $stable({data_addr_o, data_be_o, data_we_o, data_wdata_o}))) else begin
    $display("bus request changed before grant at %0t", $time);
    errors++;
  end

  task automatic idle_checks();
    check("data_req_o", word_t'(data_req_o), 32'h0);
    check("busy_o", word_t'(busy_o), 32'h0);
    check("lsu_ready_ex_o", word_t'(lsu_ready_ex_o), 32'h1);
    check("lsu_ready_wb_o", word_t'(lsu_ready_wb_o), 32'h1);
  endtask

  initial begin
    errors = 0;
    checks = 0;
    tests = 0;
    err_mark = 0;
    out_cnt = 0;
    seed = 43;
    rst_n = 1'b0;
    data_req_ex = 1'b0;
    data_we_ex = 1'b0;
    data_type_ex = SIZE_WORD;
    data_sign_ext_ex = EXT_ZERO;
    data_wdata_ex = '0;
    data_reg_offset_ex = '0;
    operand_a_ex = '0;
    operand_b_ex = '0;
    addr_useincr_ex = 1'b0;
    data_misaligned_ex = 1'b0;
    exp_addr = '0;
    exp_be = '0;
    exp_wdata = '0;
    exp_we = 1'b0;
    cur_chk = 1'b0;
    cur_val = '0;
    for (int i = 0; i < 256; i++) begin
      for (int b = 0; b < 4; b++) begin
        shadow[4*i + b] = 8'({~i[7:0], i[7:0] ^ 8'ha5, i[7:0] + 8'h3c, i[7:0]} >> (8*b));
      end
    end
    repeat (16) begin
      @(posedge clk);
      idle_checks();
    end
    #2 rst_n = 1'b1;
    @(posedge clk);
    idle_checks();
    end_test("reset and idle");
    do_store(32'h40, SIZE_WORD, 32'hcafe_f00d, 2'd0, 1'b0);
    do_load(32'h40, SIZE_WORD, EXT_ZERO, 1'b0);
    end_test("aligned word");
    for (int o = 0; o < 4; o++) begin
      do_store(32'h80 + o, SZ_BYTE, 32'h1122_3384 + o, 2'd0, 1'b0);
      do_load(32'h80 + o, SZ_BYTE, ext_t'(o % 3), 1'b0);
    end
    do_store(32'h85, SZ_BYTE, 32'h44f0_2211, 2'd2, 1'b1);   // register byte 2
    do_load(32'h85, SZ_BYTE, EXT_SIGN, 1'b1);
    do_store(32'h90, SIZE_HALF, 32'h0000_9abc, 2'd0, 1'b0);
    do_store(32'h96, SIZE_HALF, 32'h8765_0000, 2'd2, 1'b1);
    do_load(32'h90, SIZE_HALF, EXT_SIGN, 1'b1);
    do_load(32'h96, SIZE_HALF, EXT_ZERO, 1'b0);
    do_load(32'h91, SIZE_HALF, EXT_ONES, 1'b0);
    end_test("byte and halfword");
    do_store(32'h101, SIZE_WORD, 32'hdead_beef, 2'd0, 1'b0);
    do_load(32'h101, SIZE_WORD, EXT_ZERO, 1'b0);
    do_load(32'h102, SIZE_WORD, EXT_ZERO, 1'b1);
    do_load(32'h103, SIZE_WORD, EXT_ZERO, 1'b0);
    do_store(32'h10b, SIZE_HALF, 32'h0000_f00f, 2'd0, 1'b0);
    do_load(32'h10b, SIZE_HALF, EXT_SIGN, 1'b0);
    do_load(32'h107, SIZE_HALF, EXT_ONES, 1'b1);
    end_test("misaligned access");
    for (int n = 0; n < 24; n++) begin
      addr_t a;
      a = 32'h200 + (($random(seed) & 32'hff) & ~32'h3) + ($random(seed) & 32'h3);
      if ($random(seed) & 1) do_store(a, size_t'($random(seed) & 3), $random(seed), 2'd0, 1'b0);
      else do_load(a, size_t'($random(seed) & 3), ext_t'(($random(seed) & 32'h7fff) % 3), 1'b1);
    end
    end_test("back-pressure");
    $display("tests %0d checks %0d errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: test/lsu_mem_model.sv
// bus memory model for the lsu testbench
// 256 words, grant after 0 to 3 cycles, in-order responses 1 to 2 cycles after grant

`timescale 1ns/1ps

module lsu_mem_model (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  input  logic        we_i,
  input  logic [3:0]  be_i,
  input  logic [31:0] wdata_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o
);

  logic [31:0] mem [0:255];
  logic [31:0] rq_data [$];  // pending read data, oldest first
  int          rq_due [$];   // cycle from which each response may go out
  int          cyc;
  int          gnt_wait;     // -1 means no delay drawn yet
  int          seed;
  int          r;

  initial begin
    seed     = 43;
    cyc      = 0;
    gnt_wait = -1;
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = {~i[7:0], i[7:0] ^ 8'ha5, i[7:0] + 8'h3c, i[7:0]};  // every byte tracks the index
    end
  end

  always @(posedge clk) begin
    cyc++;
    if (gnt_o && req_i) begin            // accepted at this edge
      for (int l = 0; l < 4; l++) begin
        if (we_i && be_i[l]) mem[addr_i[9:2]][8*l +: 8] = wdata_i[8*l +: 8];
      end
      r = $random(seed);
      rq_data.push_back(mem[addr_i[9:2]]);
      rq_due.push_back(cyc + (r & 1));
      gnt_wait = -1;
    end
    #5;
    rvalid_o = 1'b0;
    if (rst_n && rq_due.size() != 0 && rq_due[0] <= cyc) begin
      rvalid_o = 1'b1;
      rdata_o  = rq_data.pop_front();
      void'(rq_due.pop_front());
    end
    gnt_o = 1'b0;
    if (rst_n && req_i) begin
      if (gnt_wait < 0) begin
        r = $random(seed);
        gnt_wait = r & 3;                // new delay per request
      end
      gnt_o = (gnt_wait == 0);
      if (gnt_wait > 0) gnt_wait--;
    end
  end

endmodule

// File: hw/lsu_top.sv
// lsu top level
// data-side load/store unit between the EX/WB pipeline and a req/gnt/rvalid bus

`timescale 1ns/1ps

module lsu_top import lsu_mem_pkg::*, lsu_op_pkg::*; #(
  parameter int unsigned DEPTH = 2  // max outstanding bus transactions
) (
  input  logic    clk,
  input  logic    rst_n,
  // EX stage
  input  logic    data_req_ex_i,
  input  logic    data_we_ex_i,
  input  size_t   data_type_ex_i,
  input  ext_t    data_sign_ext_ex_i,
  input  word_t   data_wdata_ex_i,
  input  offset_t data_reg_offset_ex_i,
  input  addr_t   operand_a_ex_i,
  input  addr_t   operand_b_ex_i,
  input  logic    addr_useincr_ex_i,
  input  logic    data_misaligned_ex_i,
  output logic    data_misaligned_o,
  output word_t   data_rdata_ex_o,
  output logic    lsu_ready_ex_o,
  output logic    lsu_ready_wb_o,
  output logic    busy_o,
  // data bus
  output logic    data_req_o,
  input  logic    data_gnt_i,
  input  logic    data_rvalid_i,
  output addr_t   data_addr_o,
  output logic    data_we_o,
  output be_t     data_be_o,
  output word_t   data_wdata_o,
  input  word_t   data_rdata_i
);

  logic    ctrl_update;  // EX access moves to WB
  offset_t addr_offset;
  logic    resp_valid;
  word_t   resp_rdata;

  lsu_trans_if   trans_if ();
  lsu_wb_ctrl_if wb_if ();

  //////////////////////////////
  // request side
  //////////////////////////////

  lsu_req_align u_req_align (
    .data_type_i          (data_type_ex_i),
    .data_we_i            (data_we_ex_i),
    .data_wdata_i         (data_wdata_ex_i),
    .data_reg_offset_i    (data_reg_offset_ex_i),
    .operand_a_i          (operand_a_ex_i),
    .operand_b_i          (operand_b_ex_i),
    .addr_useincr_i       (addr_useincr_ex_i),
    .data_misaligned_ex_i (data_misaligned_ex_i),
    .data_req_i           (data_req_ex_i),
    .data_misaligned_o    (data_misaligned_o),
    .addr_offset_o        (addr_offset),
    .trans                (trans_if.req_src)
  );

  lsu_txn_ctrl #(.DEPTH(DEPTH)) u_txn_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_i     (data_req_ex_i),
    .resp_valid_i   (resp_valid),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o),
    .ctrl_update_o  (ctrl_update),
    .trans          (trans_if.valid_src)
  );

  lsu_obi_port u_obi_port (
    .clk           (clk),
    .rst_n         (rst_n),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .trans         (trans_if.sink),
    .data_req_o    (data_req_o),
    .data_addr_o   (data_addr_o),
    .data_we_o     (data_we_o),
    .data_be_o     (data_be_o),
    .data_wdata_o  (data_wdata_o),
    .resp_valid_o  (resp_valid),
    .resp_rdata_o  (resp_rdata)
  );

  //////////////////////////////
  // response side
  //////////////////////////////

  lsu_wb_regs u_wb_regs (
    .clk             (clk),
    .rst_n           (rst_n),
    .ctrl_update_i   (ctrl_update),
    .data_type_i     (data_type_ex_i),
    .addr_offset_i   (addr_offset),
    .data_sign_ext_i (data_sign_ext_ex_i),
    .data_we_i       (data_we_ex_i),
    .wb              (wb_if.source)
  );

  lsu_rdata_align u_rdata_align (
    .clk                  (clk),
    .rst_n                (rst_n),
    .resp_valid_i         (resp_valid),
    .resp_rdata_i         (resp_rdata),
    .data_misaligned_ex_i (data_misaligned_ex_i),
    .data_misaligned_i    (data_misaligned_o),
    .wb                   (wb_if.sink),
    .data_rdata_o         (data_rdata_ex_o)
  );

endmodule

// File: hw/lsu_obi_port.sv
// lsu bus master port
// passes requests straight through when idle and replays a registered copy
// until the grant arrives

`timescale 1ns/1ps

module lsu_obi_port import lsu_mem_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        data_gnt_i,
  input  logic        data_rvalid_i,
  input  word_t       data_rdata_i,
  lsu_trans_if.sink   trans,
  output logic        data_req_o,
  output addr_t       data_addr_o,
  output logic        data_we_o,
  output be_t         data_be_o,
  output word_t       data_wdata_o,
  output logic        resp_valid_o,
  output word_t       resp_rdata_o
);

  typedef enum logic {IDLE, WAIT_GNT} obi_state_e;

  obi_state_e state_q, state_d;
  addr_t      addr_q;    // held request payload
  logic       we_q;
  be_t        be_q;
  word_t      wdata_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:     if (trans.trans_valid && !data_gnt_i) state_d = WAIT_GNT;
      WAIT_GNT: if (data_gnt_i) state_d = IDLE;
      default:  state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) state_q <= IDLE;
    else state_q <= state_d;
  end

  // capture when the first cycle goes ungranted
  always_ff @(posedge clk) begin
    if (state_q == IDLE && trans.trans_valid && !data_gnt_i) begin
      addr_q  <= trans.addr;
      we_q    <= trans.we;
      be_q    <= trans.be;
      wdata_q <= trans.wdata;
    end
  end

  //////////////////////////////
  // bus drive
  //////////////////////////////

  assign data_req_o   = (state_q == WAIT_GNT) || trans.trans_valid;
  assign data_addr_o  = (state_q == WAIT_GNT) ? addr_q  : trans.addr;
  assign data_we_o    = (state_q == WAIT_GNT) ? we_q    : trans.we;
  assign data_be_o    = (state_q == WAIT_GNT) ? be_q    : trans.be;
  assign data_wdata_o = (state_q == WAIT_GNT) ? wdata_q : trans.wdata;
  assign trans.trans_ready = data_gnt_i;  // accepted in the grant cycle
  assign resp_valid_o = data_rvalid_i;
  assign resp_rdata_o = data_rdata_i;

  // pending request holds its address phase
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (data_req_o && !data_gnt_i) |=> ($stable(data_addr_o) && $stable(data_be_o)));

endmodule

// File: hw/lsu_rdata_align.sv
// lsu load data aligner
// picks the loaded field at the WB offset, extends it and joins the two
// halves of a split access using the held first response

`timescale 1ns/1ps

module lsu_rdata_align import lsu_mem_pkg::*, lsu_op_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            resp_valid_i,
  input  word_t           resp_rdata_i,
  input  logic            data_misaligned_ex_i,  // EX already in phase two
  input  logic            data_misaligned_i,     // EX still in phase one
  lsu_wb_ctrl_if.sink     wb,
  output word_t           data_rdata_o
);

  word_t       rdata_q;    // first half of a split load, or last result
  word_t       rdata_w;    // word result
  word_t       rdata_ext;  // selected and extended result
  logic [15:0] half;       // raw halfword
  logic [7:0]  byte_v;     // raw byte

  // fill bit for the upper part
  function automatic logic fill_bit(input ext_t mode, input logic msb);
    case (mode)
      EXT_ZERO: return 1'b0;
      EXT_ONES: return 1'b1;
      default:  return msb;   // sign
    endcase
  endfunction

  //////////////////////////////
  // field select
  //////////////////////////////

  always_comb begin
    case (wb.offset)
      2'd0: begin
        rdata_w = resp_rdata_i;
        half    = resp_rdata_i[15:0];
        byte_v  = resp_rdata_i[7:0];
      end
      2'd1: begin
        rdata_w = {resp_rdata_i[7:0], rdata_q[31:8]};   // low lanes from next word
        half    = resp_rdata_i[23:8];
        byte_v  = resp_rdata_i[15:8];
      end
      2'd2: begin
        rdata_w = {resp_rdata_i[15:0], rdata_q[31:16]};
        half    = resp_rdata_i[31:16];
        byte_v  = resp_rdata_i[23:16];
      end
      default: begin
        rdata_w = {resp_rdata_i[23:0], rdata_q[31:24]};
        half    = {resp_rdata_i[7:0], rdata_q[31:24]};  // crosses into next word
        byte_v  = resp_rdata_i[31:24];
      end
    endcase
  end

  always_comb begin
    case (wb.size)
      SIZE_WORD: rdata_ext = rdata_w;
      SIZE_HALF: rdata_ext = {{16{fill_bit(wb.ext, half[15])}}, half};
      default:   rdata_ext = {{24{fill_bit(wb.ext, byte_v[7])}}, byte_v};
    endcase
  end

  // raw data during phase one, final result otherwise
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (resp_valid_i && !wb.we) begin
      if (data_misaligned_ex_i || data_misaligned_i) rdata_q <= resp_rdata_i;
      else rdata_q <= rdata_ext;
    end
  end

  assign data_rdata_o = resp_valid_i ? rdata_ext : rdata_q;  // live on rvalid, held after

endmodule

// File: hw/lsu_wb_regs.sv
// lsu WB control registers
// hold size, offset, extension and direction of the access waiting for its response

`timescale 1ns/1ps

module lsu_wb_regs import lsu_op_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             ctrl_update_i,   // EX access enters WB
  input  size_t            data_type_i,
  input  offset_t          addr_offset_i,
  input  ext_t             data_sign_ext_i,
  input  logic             data_we_i,
  lsu_wb_ctrl_if.source    wb
);

  //////////////////////////////
  // capture on EX to WB move
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb.size   <= SIZE_WORD;
      wb.offset <= '0;
      wb.ext    <= EXT_ZERO;
      wb.we     <= 1'b0;
    end else if (ctrl_update_i) begin
      wb.size   <= data_type_i;
      wb.offset <= addr_offset_i;   // unaligned offset, also kept for phase two
      wb.ext    <= data_sign_ext_i;
      wb.we     <= data_we_i;
    end
  end

endmodule

// File: hw/lsu_txn_ctrl.sv
// lsu transaction controller
// counts accesses in flight, gates new requests at DEPTH and
// produces the EX/WB ready levels and the busy flag

`timescale 1ns/1ps

module lsu_txn_ctrl #(
  parameter int unsigned DEPTH = 2  // max outstanding bus transactions
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            data_req_i,     // EX request level
  input  logic            resp_valid_i,   // bus response this cycle
  output logic            lsu_ready_ex_o,
  output logic            lsu_ready_wb_o,
  output logic            busy_o,
  output logic            ctrl_update_o,  // EX access moves to WB
  lsu_trans_if.valid_src  trans
);

  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(DEPTH);

  logic [CNT_W-1:0] cnt_q;      // outstanding transactions
  logic [CNT_W-1:0] cnt_d;
  logic             count_up;   // request accepted
  logic             count_down; // response received
  logic             accepted;

  //////////////////////////////
  // request and readiness
  //////////////////////////////

  assign trans.trans_valid = data_req_i && (cnt_q < CNT_MAX);  // hold off at DEPTH
  assign accepted = trans.trans_valid && trans.trans_ready;

  // WB free when idle, else it frees with the awaited response
  assign lsu_ready_wb_o = (cnt_q == '0) ? 1'b1 : resp_valid_i;

  // EX and WB advance in lock step once WB holds an access
  assign lsu_ready_ex_o = !data_req_i        ? 1'b1 :
                          (cnt_q == '0)      ? accepted :
                          (cnt_q < CNT_MAX)  ? (resp_valid_i && accepted) :
                                               resp_valid_i;

  assign ctrl_update_o = lsu_ready_ex_o && data_req_i;
  assign busy_o        = (cnt_q != '0) || trans.trans_valid;

  //////////////////////////////
  // outstanding counter
  //////////////////////////////

  assign count_up   = accepted;
  assign count_down = resp_valid_i;

  always_comb begin
    case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;             // none, or one in and one out
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // count stays bounded by DEPTH over any sequence of grants
  a_cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= CNT_MAX);

  // bus port only returns responses for granted requests
  a_no_spurious_resp: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid_i |-> (cnt_q != '0));

endmodule

// File: hw/lsu_req_align.sv
// lsu request aligner
// builds bus address, byte enables and rotated store data from the EX operands
// and flags accesses that need a second bus cycle

`timescale 1ns/1ps

module lsu_req_align import lsu_mem_pkg::*, lsu_op_pkg::*; (
  input  size_t           data_type_i,
  input  logic            data_we_i,
  input  word_t           data_wdata_i,
  input  offset_t         data_reg_offset_i,   // byte position of the value in the register
  input  addr_t           operand_a_i,
  input  addr_t           operand_b_i,
  input  logic            addr_useincr_i,      // a + b instead of a alone
  input  logic            data_misaligned_ex_i, // second phase of a split access
  input  logic            data_req_i,
  output logic            data_misaligned_o,
  output offset_t         addr_offset_o,
  lsu_trans_if.req_src    trans
);

  addr_t   addr_int;     // effective address
  offset_t addr_off;     // low address bits
  offset_t wdata_off;    // rotation for store data

  assign addr_int = addr_useincr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign addr_off = addr_int[1:0];
  assign addr_offset_o = addr_off;

  //////////////////////////////
  // byte enables
  //////////////////////////////

  always_comb begin
    trans.be = 4'b0000;
    case (data_type_i)
      SIZE_WORD: begin
        if (!data_misaligned_ex_i) begin
          trans.be = 4'b1111 << addr_off;           // lanes from offset upward
        end else begin
          trans.be = ~(4'b1111 << addr_off);        // remaining low lanes of next word
        end
      end
      SIZE_HALF: begin
        if (!data_misaligned_ex_i) begin
          trans.be = 4'b1000;                       // offset 3 keeps only the top lane
          if (addr_off != 2'd3) trans.be = 4'b0011 << addr_off;
        end else begin
          trans.be = 4'b0001;                       // upper byte lands in lane 0
        end
      end
      default: trans.be = 4'b0001 << addr_off;      // byte
    endcase
  end

  // rotate store data so the register field lines up with its lanes
  assign wdata_off = addr_off - data_reg_offset_i;

  always_comb begin
    case (wdata_off)
      2'd0:    trans.wdata = data_wdata_i;
      2'd1:    trans.wdata = {data_wdata_i[23:0], data_wdata_i[31:24]};
      2'd2:    trans.wdata = {data_wdata_i[15:0], data_wdata_i[31:16]};
      default: trans.wdata = {data_wdata_i[7:0], data_wdata_i[31:8]};
    endcase
  end

  // second phase goes to the aligned next word
  assign trans.addr = data_misaligned_ex_i ? {addr_int[31:2], 2'b00} : addr_int;
  assign trans.we   = data_we_i;

  // split needed for a word off boundary or a halfword crossing lane 3
  always_comb begin
    data_misaligned_o = 1'b0;
    if (data_req_i && !data_misaligned_ex_i) begin
      if (data_type_i == SIZE_WORD) data_misaligned_o = (addr_off != 2'd0);
      if (data_type_i == SIZE_HALF) data_misaligned_o = (addr_off == 2'd3);
    end
  end

endmodule

// File: hw/lsu_ifs.sv
// lsu internal bundles
// transaction request toward the bus port and WB control toward load alignment

`timescale 1ns/1ps

interface lsu_trans_if import lsu_mem_pkg::*; ();

  logic  trans_valid;  // from the transaction controller
  logic  trans_ready;  // from the bus port
  addr_t addr;
  logic  we;
  be_t   be;
  word_t wdata;

  // payload from the request aligner
  modport req_src (output addr, we, be, wdata);
  // valid/ready pair for the transaction controller
  modport valid_src (output trans_valid, input trans_ready);
  // bus port consumes the whole request
  modport sink (input trans_valid, addr, we, be, wdata, output trans_ready);

endinterface

interface lsu_wb_ctrl_if import lsu_op_pkg::*; ();

  size_t   size;    // access size of the access in WB
  offset_t offset;  // byte offset of its address
  ext_t    ext;     // extension mode for loads
  logic    we;      // store, no load data expected

  modport source (output size, offset, ext, we);
  modport sink (input size, offset, ext, we);

endinterface

// File: hw/lsu_op_pkg.sv
// lsu operation encodings
// access size, extension mode and byte offset as issued by the EX stage

package lsu_op_pkg;

  //////////////////////////////
  // access size
  //////////////////////////////

  typedef logic [1:0] size_t;  // 0 word, 1 halfword, 2 and 3 byte

  localparam size_t SIZE_WORD = 2'd0;  // 32-bit access
  localparam size_t SIZE_HALF = 2'd1;  // 16-bit access

  //////////////////////////////
  // load extension mode
  //////////////////////////////

  typedef logic [1:0] ext_t;

  localparam ext_t EXT_ZERO = 2'd0;  // fill with zeros
  localparam ext_t EXT_SIGN = 2'd1;  // replicate the field msb
  localparam ext_t EXT_ONES = 2'd2;  // fill with ones

  //////////////////////////////
  // byte position in a word
  //////////////////////////////

  typedef logic [1:0] offset_t;

endpackage

// File: hw/lsu_mem_pkg.sv
// lsu bus-side definitions
// widths and vector types seen on the data bus

package lsu_mem_pkg;

  //////////////////////////////
  // bus widths
  //////////////////////////////

  localparam int unsigned ADDR_W = 32;          // byte address width
  localparam int unsigned DATA_W = 32;          // data word width
  localparam int unsigned BE_W   = DATA_W / 8;  // one enable per byte lane

  //////////////////////////////
  // bus types
  //////////////////////////////

  typedef logic [ADDR_W-1:0] addr_t;  // byte address
  typedef logic [DATA_W-1:0] word_t;  // full data word
  typedef logic [BE_W-1:0]   be_t;    // byte-enable mask

endpackage
